// File: src/icache_pkg.sv
/* Shared widths, address field types, access width codes
   and the CPU address union for the instruction cache */

package icache_pkg;

    // Bus and line geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int WORD_OFS_W = 5;             // Word within line
    localparam int LINE_WORDS = 32;            // Also the burst length
    localparam int TAG_W      = 20;            // Address bits 26..7
    localparam int BL_W       = 10;            // Wishbone burst length field

    // CPU access width
    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'b00,
        WIDTH_HALF = 2'b01,
        WIDTH_WORD = 2'b10
    } width_e;

    // Word view of a byte address
    typedef struct packed {
        logic [ADDR_W-3:0] word_adr;
        logic [1:0]        byte_ofs;
    } addr_word_s;

    // Cache field view of the same address
    typedef struct packed {
        logic [ADDR_W-TAG_W-WORD_OFS_W-3:0] rsvd;   // Bits 31..27, ignored
        logic [TAG_W-1:0]                   tag;
        logic [WORD_OFS_W-1:0]              word_ofs;
        logic [1:0]                         byte_ofs;
    } addr_field_s;

    typedef union packed {
        addr_word_s  w;
        addr_field_s f;
    } icache_addr_u;

endpackage

// File: src/icache_tag_store.sv
/* Fully associative tag array with valid bits, parallel
   compare and the FIFO fill pointer */
`timescale 1ns/100ps

module icache_tag_store #(
    parameter int LINES = 16
) (
    input  logic                           mclk,
    input  logic                           rst_n,
    input  logic                           tag_wr_i,      // Store tag in fill slot
    input  logic [icache_pkg::TAG_W-1:0]   tag_wdata_i,
    input  logic [icache_pkg::TAG_W-1:0]   cmp_tag_i,     // From lookup address register
    output logic                           hit_o,
    output logic [$clog2(LINES)-1:0]       hit_idx_o,
    output logic [$clog2(LINES)-1:0]       fill_idx_o     // Next slot to be replaced
);

    localparam int IDX_W = $clog2(LINES);

    logic [icache_pkg::TAG_W-1:0] tag_q [LINES];
    logic [LINES-1:0]             valid_q;
    logic [IDX_W-1:0]             fill_q;

    // --------------------
    // Parallel compare
    always_comb begin
        hit_o     = 1'b0;
        hit_idx_o = '0;
        for (int i = 0; i < LINES; i++) begin
            if (valid_q[i] && (tag_q[i] == cmp_tag_i)) begin
                hit_o     = 1'b1;
                hit_idx_o = IDX_W'(i);      // Unique tags give one match at most
            end
        end
    end

    // Tag payload
    always_ff @(posedge mclk) begin
        if (tag_wr_i)
            tag_q[fill_q] <= tag_wdata_i;
    end

    // --------------------
    // Valid bits and FIFO pointer
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            fill_q  <= '0;
        end else if (tag_wr_i) begin
            valid_q[fill_q] <= 1'b1;
            if (fill_q == IDX_W'(LINES - 1))
                fill_q <= '0;               // Wrap to the oldest slot
            else
                fill_q <= fill_q + 1'b1;
        end
    end

    assign fill_idx_o = fill_q;

endmodule

// File: src/icache_line_ram.sv
/* Line data RAM, one write port and one registered read port */
`timescale 1ns/100ps

module icache_line_ram #(
    parameter int LINES = 16
) (
    input  logic                                                 mclk,
    input  logic                                                 wr_en_i,
    input  logic [$clog2(LINES)+icache_pkg::WORD_OFS_W-1:0]      wr_idx_i,   // {line, word}
    input  logic [icache_pkg::DATA_W-1:0]                        wr_data_i,
    input  logic                                                 rd_en_i,
    input  logic [$clog2(LINES)+icache_pkg::WORD_OFS_W-1:0]      rd_idx_i,   // {line, word}
    output logic [icache_pkg::DATA_W-1:0]                        rd_data_o
);

    localparam int DEPTH = LINES * icache_pkg::LINE_WORDS;

    logic [icache_pkg::DATA_W-1:0] mem [DEPTH];

    // Refill write side
    always_ff @(posedge mclk) begin
        if (wr_en_i)
            mem[wr_idx_i] <= wr_data_i;
    end

    // Read data held until the next enable
    always_ff @(posedge mclk) begin
        if (rd_en_i)
            rd_data_o <= mem[rd_idx_i];
    end

endmodule

// File: src/icache_refill.sv
/* Wishbone burst refill engine, writes a line into the RAM
   and then its tag into the tag store */
`timescale 1ns/100ps

module icache_refill #(
    parameter int LINES = 16
) (
    input  logic                                              mclk,
    input  logic                                              rst_n,
    input  logic                                              start_i,      // From lookup
    input  logic [icache_pkg::ADDR_W-1:0]                     line_addr_i,  // Line aligned
    output logic                                              done_o,
    input  logic [$clog2(LINES)-1:0]                          fill_idx_i,   // Slot to overwrite
    output logic                                              ram_wr_en_o,
    output logic [$clog2(LINES)+icache_pkg::WORD_OFS_W-1:0]   ram_wr_idx_o,
    output logic [icache_pkg::DATA_W-1:0]                     ram_wr_data_o,
    output logic                                              tag_wr_o,
    output logic [icache_pkg::TAG_W-1:0]                      tag_wdata_o,
    output logic                                              wb_stb_o,
    output logic                                              wb_we_o,
    output logic [icache_pkg::ADDR_W-1:0]                     wb_adr_o,
    output logic [icache_pkg::BL_W-1:0]                       wb_bl_o,
    input  logic [icache_pkg::DATA_W-1:0]                     wb_dat_i,
    input  logic                                              wb_ack_i,
    input  logic                                              wb_lack_i
);

    typedef enum logic [1:0] {
        RF_IDLE   = 2'd0,
        RF_BURST  = 2'd1,
        RF_FINISH = 2'd2
    } rf_state_e;

    rf_state_e                            state_q;
    icache_pkg::icache_addr_u             line_q;     // Captured at start
    logic [icache_pkg::WORD_OFS_W-1:0]    word_q;     // Ack counter
    logic                                 ack_ok;

    assign ack_ok = (state_q == RF_BURST) && wb_ack_i;

    // --------------------
    // Burst sequencing
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= RF_IDLE;
            word_q  <= '0;
        end else begin
            case (state_q)
                RF_IDLE: begin
                    word_q <= '0;
                    if (start_i)
                        state_q <= RF_BURST;    // Strobe rises next cycle
                end
                RF_BURST: begin
                    if (wb_ack_i)
                        word_q <= word_q + 1'b1;
                    if (wb_ack_i && wb_lack_i)
                        state_q <= RF_FINISH;
                end
                RF_FINISH: state_q <= RF_IDLE;  // Done pulse
                default:   state_q <= RF_IDLE;
            endcase
        end
    end

    // Address payload
    always_ff @(posedge mclk) begin
        if (start_i && (state_q == RF_IDLE))
            line_q <= line_addr_i;
    end

    // --------------------
    // Wishbone request, held for the whole burst
    assign wb_stb_o = (state_q == RF_BURST);
    assign wb_we_o  = 1'b0;                             // Read only
    assign wb_adr_o = line_q;
    assign wb_bl_o  = icache_pkg::BL_W'(icache_pkg::LINE_WORDS);

    // RAM write per ack into the fill slot
    assign ram_wr_en_o   = ack_ok;
    assign ram_wr_idx_o  = {fill_idx_i, word_q};
    assign ram_wr_data_o = wb_dat_i;

    // Tag goes in with the last word
    assign tag_wr_o    = ack_ok && wb_lack_i;
    assign tag_wdata_o = line_q.f.tag;

    assign done_o = (state_q == RF_FINISH);

endmodule

// File: src/icache_lookup.sv
/* CPU side controller: tag compare sequencing, miss handling
   and byte/halfword extraction */
`timescale 1ns/100ps

module icache_lookup #(
    parameter int LINES = 16
) (
    input  logic                                              mclk,
    input  logic                                              rst_n,
    input  logic                                              cpu_req_i,
    input  logic [icache_pkg::ADDR_W-1:0]                     cpu_addr_i,
    input  icache_pkg::width_e                                cpu_width_i,
    output logic                                              cpu_busy_o,
    output logic                                              cpu_rvalid_o,
    output logic [icache_pkg::DATA_W-1:0]                     cpu_rdata_o,
    output logic [icache_pkg::TAG_W-1:0]                      cmp_tag_o,
    input  logic                                              hit_i,
    input  logic [$clog2(LINES)-1:0]                          hit_idx_i,
    output logic                                              refill_start_o,
    output logic [icache_pkg::ADDR_W-1:0]                     refill_addr_o,
    input  logic                                              refill_done_i,
    output logic                                              ram_rd_en_o,
    output logic [$clog2(LINES)+icache_pkg::WORD_OFS_W-1:0]   ram_rd_idx_o,
    input  logic [icache_pkg::DATA_W-1:0]                     ram_rd_data_i
);

    localparam int OFS_W = icache_pkg::WORD_OFS_W;

    typedef enum logic [2:0] {
        LK_IDLE    = 3'd0,
        LK_COMPARE = 3'd1,
        LK_READ    = 3'd2,
        LK_RESP    = 3'd3,
        LK_REFILL  = 3'd4
    } lk_state_e;

    lk_state_e                   state_q;
    icache_pkg::icache_addr_u    req_q;         // Latched CPU address
    icache_pkg::width_e          width_q;
    logic [$clog2(LINES)-1:0]    line_q;        // Hit slot
    logic                        start_q;
    logic [icache_pkg::DATA_W-1:0] lane;

    // --------------------
    // Request FSM
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LK_IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                LK_IDLE: if (cpu_req_i) state_q <= LK_COMPARE;
                LK_COMPARE: begin
                    if (hit_i) begin
                        state_q <= LK_READ;
                    end else begin
                        start_q <= 1'b1;            // One refill pulse
                        state_q <= LK_REFILL;
                    end
                end
                LK_READ:   state_q <= LK_RESP;
                LK_RESP:   state_q <= LK_IDLE;
                LK_REFILL: if (refill_done_i) state_q <= LK_COMPARE;  // Now hits
                default:   state_q <= LK_IDLE;
            endcase
        end
    end

    // Request and hit slot payload
    always_ff @(posedge mclk) begin
        if ((state_q == LK_IDLE) && cpu_req_i) begin
            req_q   <= cpu_addr_i;
            width_q <= cpu_width_i;
        end
        if ((state_q == LK_COMPARE) && hit_i)
            line_q <= hit_idx_i;
    end

    assign cmp_tag_o      = req_q.f.tag;
    assign refill_start_o = start_q;
    // Line base, word offset and byte bits cleared
    assign refill_addr_o  = {req_q.w.word_adr[icache_pkg::ADDR_W-3:OFS_W], {(OFS_W + 2){1'b0}}};

    assign ram_rd_en_o  = (state_q == LK_READ);
    assign ram_rd_idx_o = {line_q, req_q.f.word_ofs};

    // --------------------
    // Lane select and zero extend
    assign lane = ram_rd_data_i >> {req_q.f.byte_ofs, 3'b000};

    always_comb begin
        case (width_q)
            icache_pkg::WIDTH_BYTE: cpu_rdata_o = {24'h0, lane[7:0]};
            icache_pkg::WIDTH_HALF: cpu_rdata_o = {16'h0, lane[15:0]};  // Offset 0 or 2
            default:                cpu_rdata_o = ram_rd_data_i;
        endcase
    end

    assign cpu_rvalid_o = (state_q == LK_RESP);
    assign cpu_busy_o   = (state_q != LK_IDLE);

endmodule

// File: src/icache_top.sv
/* Instruction cache top, lookup, tag store, line RAM and refill */
`timescale 1ns/100ps

module icache_top #(
    parameter int LINES = 16
) (
    input  logic                              mclk,
    input  logic                              rst_n,
    input  logic                              cpu_req_i,
    input  logic [icache_pkg::ADDR_W-1:0]     cpu_addr_i,
    input  icache_pkg::width_e                cpu_width_i,
    output logic                              cpu_busy_o,
    output logic                              cpu_rvalid_o,
    output logic [icache_pkg::DATA_W-1:0]     cpu_rdata_o,
    output logic                              wb_stb_o,
    output logic                              wb_we_o,
    output logic [icache_pkg::ADDR_W-1:0]     wb_adr_o,
    output logic [icache_pkg::BL_W-1:0]       wb_bl_o,
    input  logic [icache_pkg::DATA_W-1:0]     wb_dat_i,
    input  logic                              wb_ack_i,
    input  logic                              wb_lack_i
);

    localparam int IDX_W = $clog2(LINES);
    localparam int RAM_W = IDX_W + icache_pkg::WORD_OFS_W;

    // --------------------
    // Internal wiring
    logic [icache_pkg::TAG_W-1:0]  cmp_tag, tag_wdata;
    logic                          hit, tag_wr;
    logic [IDX_W-1:0]              hit_idx, fill_idx;
    logic                          refill_start, refill_done;
    logic [icache_pkg::ADDR_W-1:0] refill_addr;
    logic                          ram_wr_en, ram_rd_en;
    logic [RAM_W-1:0]              ram_wr_idx, ram_rd_idx;
    logic [icache_pkg::DATA_W-1:0] ram_wr_data, ram_rd_data;

    icache_lookup #(.LINES(LINES)) u_lookup (
        .mclk(mclk), .rst_n(rst_n),
        .cpu_req_i(cpu_req_i), .cpu_addr_i(cpu_addr_i), .cpu_width_i(cpu_width_i),
        .cpu_busy_o(cpu_busy_o), .cpu_rvalid_o(cpu_rvalid_o), .cpu_rdata_o(cpu_rdata_o),
        .cmp_tag_o(cmp_tag), .hit_i(hit), .hit_idx_i(hit_idx),
        .refill_start_o(refill_start), .refill_addr_o(refill_addr),
        .refill_done_i(refill_done),
        .ram_rd_en_o(ram_rd_en), .ram_rd_idx_o(ram_rd_idx), .ram_rd_data_i(ram_rd_data)
    );

    icache_tag_store #(.LINES(LINES)) u_tags (
        .mclk(mclk), .rst_n(rst_n),
        .tag_wr_i(tag_wr), .tag_wdata_i(tag_wdata), .cmp_tag_i(cmp_tag),
        .hit_o(hit), .hit_idx_o(hit_idx), .fill_idx_o(fill_idx)
    );

    icache_line_ram #(.LINES(LINES)) u_ram (
        .mclk(mclk),
        .wr_en_i(ram_wr_en), .wr_idx_i(ram_wr_idx), .wr_data_i(ram_wr_data),
        .rd_en_i(ram_rd_en), .rd_idx_i(ram_rd_idx), .rd_data_o(ram_rd_data)
    );

    icache_refill #(.LINES(LINES)) u_refill (
        .mclk(mclk), .rst_n(rst_n),
        .start_i(refill_start), .line_addr_i(refill_addr), .done_o(refill_done),
        .fill_idx_i(fill_idx),
        .ram_wr_en_o(ram_wr_en), .ram_wr_idx_o(ram_wr_idx), .ram_wr_data_o(ram_wr_data),
        .tag_wr_o(tag_wr), .tag_wdata_o(tag_wdata),
        .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o), .wb_bl_o(wb_bl_o),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i), .wb_lack_i(wb_lack_i)
    );

endmodule

// File: test/tb_icache_mem.sv
/* Burst Wishbone memory model, one ack per cycle after a short
   delay, data computed from the word address */
`timescale 1ns/100ps

module tb_icache_mem #(
    parameter logic [31:0] KEY = 32'hA5C3_0000
) (
    input  logic        mclk,
    input  logic        rst_n,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    input  logic [9:0]  wb_bl_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        wb_lack_o
);

    logic       busy_q;     // Burst in progress
    logic       drain_q;    // Last ack sent, strobe still up
    logic [1:0] dly_q;
    logic [9:0] cnt_q;      // Words already acked

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            drain_q   <= 1'b0;
            dly_q     <= '0;
            cnt_q     <= '0;
            wb_dat_o  <= '0;
            wb_ack_o  <= 1'b0;
            wb_lack_o <= 1'b0;
        end else begin
            wb_ack_o  <= 1'b0;
            wb_lack_o <= 1'b0;
            if (drain_q) begin
                drain_q <= wb_stb_i;                // Stay until strobe drops
            end else if (!busy_q) begin
                if (wb_stb_i && !wb_we_i) begin
                    busy_q <= 1'b1;
                    dly_q  <= 2'd2;                 // Initial latency
                    cnt_q  <= '0;
                end
            end else if (dly_q != 2'd0) begin
                dly_q <= dly_q - 2'd1;
            end else begin
                wb_ack_o <= 1'b1;
                // Word address of this beat, scrambled
                wb_dat_o <= ({2'b00, wb_adr_i[31:2]} + 32'(cnt_q)) ^ KEY;
                cnt_q    <= cnt_q + 10'd1;
                if (cnt_q == wb_bl_i - 10'd1) begin
                    wb_lack_o <= 1'b1;              // Last beat
                    busy_q    <= 1'b0;
                    drain_q   <= 1'b1;
                end
            end
        end
    end

endmodule

// File: test/tb_icache.sv
/* Instruction cache testbench with clock, reset, stimulus table,
   FIFO tag model, burst monitor and result checks */
`timescale 1ns/100ps

module tb_icache;

    localparam int          LINES   = 16;
    localparam int          NT      = 48;               // Table capacity
    localparam int          TMO     = 400;              // Cycles per wait
    localparam int          NRAND   = 12;
    localparam logic [31:0] MEM_KEY = 32'hA5C3_0000;
    localparam logic [31:0] BASE    = 32'h0000_1000;

    logic               mclk;
    logic               rst_n;
    logic               cpu_req;
    logic [31:0]        cpu_addr;
    icache_pkg::width_e cpu_width;
    logic               cpu_busy;
    logic               cpu_rvalid;
    logic [31:0]        cpu_rdata;
    logic               wb_stb;
    logic               wb_we;
    logic [31:0]        wb_adr;
    logic [9:0]         wb_bl;
    logic [31:0]        wb_dat;
    logic               wb_ack;
    logic               wb_lack;

    // Stimulus table
    string              t_name  [NT];
    logic [31:0]        t_addr  [NT];
    icache_pkg::width_e t_width [NT];
    bit                 t_miss  [NT];
    int                 n_tests;
    logic [19:0]        fifo_q [$];                     // Tag FIFO reference

    // Burst monitor state
    logic               stb_d;
    int                 bursts;
    logic [31:0]        burst_adr;
    logic [9:0]         burst_bl;
    logic               burst_we;

    icache_top #(.LINES(LINES)) DUT (
        .mclk(mclk), .rst_n(rst_n),
        .cpu_req_i(cpu_req), .cpu_addr_i(cpu_addr), .cpu_width_i(cpu_width),
        .cpu_busy_o(cpu_busy), .cpu_rvalid_o(cpu_rvalid), .cpu_rdata_o(cpu_rdata),
        .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr), .wb_bl_o(wb_bl),
        .wb_dat_i(wb_dat), .wb_ack_i(wb_ack), .wb_lack_i(wb_lack)
    );

    tb_icache_mem #(.KEY(MEM_KEY)) u_mem (
        .mclk(mclk), .rst_n(rst_n),
        .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_bl_i(wb_bl),
        .wb_dat_o(wb_dat), .wb_ack_o(wb_ack), .wb_lack_o(wb_lack)
    );

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;                       // 50 MHz
    end

    // --------------------
    // Count bursts on strobe rise and keep the request fields
    always @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            stb_d  <= 1'b0;
            bursts <= 0;
        end else begin
            stb_d <= wb_stb;
            if (wb_stb && !stb_d) begin
                bursts    <= bursts + 1;
                burst_adr <= wb_adr;
                burst_bl  <= wb_bl;
                burst_we  <= wb_we;
            end
        end
    end

    task automatic add_test(input string name, input logic [31:0] addr,
                            input icache_pkg::width_e width, input bit miss);
        t_name[n_tests]  = name;
        t_addr[n_tests]  = addr;
        t_width[n_tests] = width;
        t_miss[n_tests]  = miss;
        n_tests++;
    endtask

    // Returns 1 when the FIFO model of line tags misses
    function automatic bit model_access(input logic [31:0] addr);
        for (int j = 0; j < fifo_q.size(); j++)
            if (fifo_q[j] == addr[26:7])
                return 1'b0;
        fifo_q.push_back(addr[26:7]);
        if (fifo_q.size() > LINES)
            void'(fifo_q.pop_front());                  // Oldest line leaves
        return 1'b1;
    endfunction

    // Memory word and the addressed lane, zero extended
    function automatic logic [31:0] expect_data(input logic [31:0] addr,
                                                input icache_pkg::width_e width);
        logic [31:0] word;
        word = {2'b00, addr[31:2]} ^ MEM_KEY;
        case (width)
            icache_pkg::WIDTH_BYTE: return {24'h0, word[8 * addr[1:0] +: 8]};
            icache_pkg::WIDTH_HALF: return {16'h0, word[16 * addr[1] +: 16]};
            default:                return word;
        endcase
    endfunction

    // --------------------
    // Build the table, then apply it
    initial begin
        int          seed;
        int          lat;
        int          b0;
        int          passes;
        int          fails;
        bit          ok;
        bit          busy_dropped;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] exp_data;

        seed      = 32'h6580;
        passes    = 0;
        fails     = 0;
        n_tests   = 0;
        rst_n     <= 1'b0;
        cpu_req   <= 1'b0;
        cpu_addr  <= '0;
        cpu_width <= icache_pkg::WIDTH_WORD;

        add_test("first_miss", BASE + 32'h10, icache_pkg::WIDTH_WORD, 1'b1);
        add_test("same_line_hit", BASE + 32'h44, icache_pkg::WIDTH_WORD, 1'b0);
        for (int b = 0; b < 4; b++)
            add_test($sformatf("byte_ofs%0d", b), BASE + 32'h20 + b,
                     icache_pkg::WIDTH_BYTE, 1'b0);
        add_test("half_low", BASE + 32'h30, icache_pkg::WIDTH_HALF, 1'b0);
        add_test("half_high", BASE + 32'h32, icache_pkg::WIDTH_HALF, 1'b0);
        for (int k = 1; k <= LINES; k++)               // 17 lines in use after this
            add_test($sformatf("fill_line%0d", k), BASE + k * 128 + 4 * k,
                     icache_pkg::WIDTH_WORD, 1'b1);
        add_test("second_line_hit", BASE + 32'h88, icache_pkg::WIDTH_WORD, 1'b0);
        add_test("first_line_evicted", BASE + 32'h04, icache_pkg::WIDTH_WORD, 1'b1);

        // Replay fixed entries so random ones see the real FIFO state
        for (int i = 0; i < n_tests; i++)
            void'(model_access(t_addr[i]));
        for (int i = 0; i < NRAND; i++) begin
            r = $random(seed);
            a = BASE + ((32'd20 + 32'(r[1:0])) << 7) + 32'({r[6:2], 2'b00});
            add_test($sformatf("rand%0d", i), a, icache_pkg::WIDTH_WORD, model_access(a));
        end

        repeat (5) @(posedge mclk);
        rst_n <= 1'b1;

        for (int i = 0; i < n_tests; i++) begin
            ok = 1'b1;
            busy_dropped = 1'b0;
            @(posedge mclk);
            assert (!cpu_busy) else begin
                $display("%s: cache still busy when the request was issued", t_name[i]);
                ok = 1'b0;
            end
            cpu_req   <= 1'b1;                          // One-cycle strobe
            cpu_addr  <= t_addr[i];
            cpu_width <= t_width[i];
            b0 = bursts;
            @(posedge mclk);
            cpu_req <= 1'b0;
            lat = 0;
            while (!cpu_rvalid && lat < TMO) begin
                @(posedge mclk);
                lat++;
                if (!cpu_busy)
                    busy_dropped = 1'b1;                // Busy spans the whole request
            end
            if (!cpu_rvalid) begin
                $display("%s: no read response within %0d cycles", t_name[i], TMO);
                fails++;
                break;
            end
            assert (!busy_dropped) else begin
                $display("%s: cache dropped busy before the read response", t_name[i]);
                ok = 1'b0;
            end
            exp_data = expect_data(t_addr[i], t_width[i]);
            assert (cpu_rdata == exp_data) else begin
                $display("mismatch %s: expected %h, actual %h", t_name[i], exp_data, cpu_rdata);
                ok = 1'b0;
            end
            assert ((bursts - b0) == int'(t_miss[i])) else begin
                $display("mismatch %s: expected %0d bursts, actual %0d", t_name[i],
                         int'(t_miss[i]), bursts - b0);
                ok = 1'b0;
            end
            if (t_miss[i]) begin
                assert (burst_adr == {t_addr[i][31:7], 7'h00} && burst_bl == 10'd32
                        && !burst_we) else begin
                    $display("mismatch %s: expected adr %h bl 32 we 0, actual adr %h bl %0d we %b",
                             t_name[i], {t_addr[i][31:7], 7'h00}, burst_adr, burst_bl, burst_we);
                    ok = 1'b0;
                end
            end else begin
                assert (lat == 3) else begin             // Fixed hit latency
                    $display("mismatch %s: expected latency 3, actual %0d", t_name[i], lat);
                    ok = 1'b0;
                end
            end
            if (ok)
                passes++;
            else
                fails++;
            $display("%-20s %s, latency %0d", t_name[i], ok ? "ok" : "failed", lat);
        end

        $display("%0d tests: %0d passed, %0d failed", n_tests, passes, fails);
        if (fails == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: compile.f
src/icache_pkg.sv
src/icache_tag_store.sv
src/icache_line_ram.sv
src/icache_refill.sv
src/icache_lookup.sv
src/icache_top.sv
test/tb_icache_mem.sv
test/tb_icache.sv

// File: Makefile
# Verilator flow for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
